//--- src/noc_params.svh
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

////////////////////////////////////////
// core word fields, msb first
////////////////////////////////////////

`define ROUTE_W 5     // destination route
`define CODE_W 7      // opaque code, carried through
`define PAYLOAD_W 20  // split into two 10-bit data flits

////////////////////////////////////////
// router side
////////////////////////////////////////

`define FLIT_W 11     // tail bit + 10-bit body

// lane count, route modulo this picks the lane
`define NUM_LANES 4
`define FIFO_DEPTH 8  // flits per lane fifo

// header body gets bit 9 only for this route
`define BCAST_ROUTE 16

`endif

//--- src/noc_pkg.sv
`include "noc_params.svh"

package noc_pkg;

	////////////////////////////////////////
	// core side word
	////////////////////////////////////////

	// [route | code | payload], 5 + 7 + 20
	typedef struct packed {
		logic [`ROUTE_W-1:0] route;
		logic [`CODE_W-1:0] code;
		logic [`PAYLOAD_W-1:0] payload;
	} core_word_t;

	////////////////////////////////////////
	// router side flit
	////////////////////////////////////////

	// tail sits in the msb
	typedef struct packed {
		logic tail;                 // last flit of a packet
		logic [`FLIT_W-2:0] body;   // route, code or payload half
	} flit_t;

	// lane number, route modulo lane count
	typedef logic [$clog2(`NUM_LANES)-1:0] lane_idx_t;

endpackage

//--- src/core_dispatch.sv
`timescale 1ns/1ps
`include "noc_params.svh"

// one-word holding stage between the core and the serializer lanes
module core_dispatch import noc_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  core_valid,
	input  core_word_t            core_word,
	output logic                  core_ack,
	output logic [`NUM_LANES-1:0] lane_valid,
	output core_word_t            lane_word,
	input  logic [`NUM_LANES-1:0] lane_ack
);

	logic       held_full;  // holding register occupied
	core_word_t held_word;  // word waiting for its lane
	lane_idx_t  held_lane;  // lane picked from the route

	// same route -> same lane, keeps per-route order
	assign held_lane = lane_idx_t'(held_word.route % `NUM_LANES);

	assign core_ack  = !held_full; // take a new word only when empty
	assign lane_word = held_word;  // broadcast, valid picks the lane

	always_comb begin
		for (int i = 0; i < `NUM_LANES; i++) begin
			lane_valid[i] = held_full && (held_lane == i);
		end
	end

	// occupancy flag
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			held_full <= 1'b0;
		end else if (core_valid && core_ack) begin
			held_full <= 1'b1;              // accepted, lane sees it next cycle
		end else if (held_full && lane_ack[held_lane]) begin
			held_full <= 1'b0;              // lane consumed it
		end
	end

	// payload register
	always_ff @(posedge clk) begin
		if (core_valid && core_ack) begin
			held_word <= core_word;
		end
	end

endmodule

//--- src/word_serializer.sv
`timescale 1ns/1ps
`include "noc_params.svh"

// turns core words into one header flit plus three data flits per word
// back to back words with the same route share one packet
module word_serializer import noc_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       in_valid,
	input  core_word_t in_word,
	output logic       in_ack,
	output logic       wrreq,
	output flit_t      flit,
	input  logic       full
);

	localparam int BODY_W = `FLIT_W - 1;     // 10
	localparam int HALF_W = `PAYLOAD_W / 2;  // payload split point

	////////////////////////////////////////
	// state
	////////////////////////////////////////

	typedef enum logic [2:0] {
		S_IDLE,    // nothing latched
		S_HEADER,  // route flit
		S_CODE,    // code flit, acks the word
		S_PAY_HI,  // payload [19:10]
		S_PAY_LO   // payload [9:0], tail unless merged
	} ser_state_t;

	ser_state_t state;
	ser_state_t next_state;

	core_word_t cur_word;     // word being serialized
	logic       latch;        // load in_word this cycle
	logic       same_route;   // next word can join this packet
	logic [BODY_W-1:0] hdr_body;

	// broadcast route gets the marker bit, everything else plain route
	assign hdr_body = (cur_word.route == `BCAST_ROUTE) ?
		BODY_W'(1) << (BODY_W - 1) : BODY_W'(cur_word.route);

	assign same_route = in_valid && (in_word.route == cur_word.route);

	////////////////////////////////////////
	// next state and flit mux
	////////////////////////////////////////

	always_comb begin
		next_state = state;
		latch      = 1'b0;
		wrreq      = 1'b0;
		in_ack     = 1'b0;
		flit       = '0;

		case (state)
			S_IDLE: begin
				if (in_valid) begin
					latch      = 1'b1;      // header goes out next cycle
					next_state = S_HEADER;
				end
			end

			S_HEADER: begin
				wrreq     = !full;
				flit.tail = 1'b0;
				flit.body = hdr_body;
				if (!full) begin
					next_state = S_CODE;
				end
			end

			S_CODE: begin
				wrreq     = !full;
				in_ack    = !full;       // dispatcher frees the word here
				flit.body = BODY_W'(cur_word.code); // upper bits zero
				if (!full) begin
					next_state = S_PAY_HI;
				end
			end

			S_PAY_HI: begin
				wrreq     = !full;
				flit.body = cur_word.payload[`PAYLOAD_W-1:HALF_W];
				if (!full) begin
					next_state = S_PAY_LO;
				end
			end

			S_PAY_LO: begin
				wrreq     = !full;
				flit.tail = !same_route;  // no tail when merging
				flit.body = cur_word.payload[HALF_W-1:0];
				if (!full) begin
					if (in_valid) begin
						latch = 1'b1;
						// same route skips tail and header
						next_state = same_route ? S_CODE : S_HEADER;
					end else begin
						next_state = S_IDLE;
					end
				end
			end

			default: begin
				next_state = S_IDLE;
			end
		endcase
	end

	////////////////////////////////////////
	// registers
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// word latch, idle or end of word
	always_ff @(posedge clk) begin
		if (latch) begin
			cur_word <= in_word;
		end
	end

endmodule

//--- src/flit_fifo.sv
`timescale 1ns/1ps
`include "noc_params.svh"

// show-ahead flit fifo, head flit always on q when not empty
module flit_fifo import noc_pkg::*; #(
	parameter int DEPTH = `FIFO_DEPTH
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  wrreq,
	input  flit_t flit,
	output logic  full,
	input  logic  rdreq,
	output logic  empty,
	output flit_t q
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	flit_t mem [DEPTH];   // storage
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;  // flits held

	logic wr_en;
	logic rd_en;

	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign wr_en = wrreq && !full;   // overflow ignored
	assign rd_en = rdreq && !empty;  // underflow ignored
	assign q     = mem[rd_ptr];      // show-ahead

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop keeps the count
			if (wr_en && !rd_en) begin
				count <= count + 1'b1;
			end else if (rd_en && !wr_en) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= flit;
		end
	end

endmodule

//--- src/flit_arbiter.sv
`timescale 1ns/1ps
`include "noc_params.svh"

// round-robin drain of the lane fifos into the router port
// a lane keeps the grant from its first popped flit up to its tail
module flit_arbiter import noc_pkg::*; (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`NUM_LANES-1:0]       empty,
	input  flit_t [`NUM_LANES-1:0]      q,
	output logic [`NUM_LANES-1:0]       rdreq,
	input  logic                        out_full,
	output logic                        out_wrreq,
	output flit_t                       out_flit
);

	lane_idx_t grant;      // last served lane
	logic      locked;     // mid-packet, grant frozen
	lane_idx_t next_lane;  // round-robin pick
	lane_idx_t cand;
	logic      found;
	lane_idx_t sel;        // lane driving the output
	logic      fire;       // one flit moves this cycle

	////////////////////////////////////////
	// round-robin search
	////////////////////////////////////////

	// first non-empty lane after grant, grant itself checked last
	always_comb begin
		next_lane = grant;
		found     = 1'b0;
		cand      = grant;
		for (int i = 1; i <= `NUM_LANES; i++) begin
			cand = lane_idx_t'((grant + i) % `NUM_LANES);
			if (!found && !empty[cand]) begin
				next_lane = cand;
				found     = 1'b1;
			end
		end
	end

	assign sel       = locked ? grant : next_lane;
	assign fire      = !out_full && !empty[sel];
	assign out_wrreq = fire;
	assign out_flit  = q[sel];

	always_comb begin
		for (int i = 0; i < `NUM_LANES; i++) begin
			rdreq[i] = fire && (sel == i);
		end
	end

	////////////////////////////////////////
	// grant and packet lock
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			grant  <= '0;
			locked <= 1'b0;
		end else if (fire) begin
			grant  <= sel;
			locked <= !q[sel].tail;  // tail releases the lane
		end
	end

endmodule

//--- src/noc_injector_top.sv
`timescale 1ns/1ps
`include "noc_params.svh"

// injection side of the node: dispatch, per-lane serialize + buffer, merge
module noc_injector_top import noc_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	// core channel
	input  logic       core_valid,
	input  core_word_t core_word,
	output logic       core_ack,
	// router fifo port
	input  logic       out_full,
	output logic       out_wrreq,
	output flit_t      out_flit
);

	// dispatcher to lanes
	logic [`NUM_LANES-1:0] lane_valid;
	logic [`NUM_LANES-1:0] lane_ack;
	core_word_t            lane_word;  // shared by all lanes

	// serializer to fifo
	logic [`NUM_LANES-1:0]  ser_wrreq;
	flit_t [`NUM_LANES-1:0] ser_flit;
	logic [`NUM_LANES-1:0]  fifo_full;

	// fifo to arbiter
	logic [`NUM_LANES-1:0]  fifo_empty;
	logic [`NUM_LANES-1:0]  fifo_rdreq;
	flit_t [`NUM_LANES-1:0] fifo_q;

	core_dispatch u_dispatch (
		.clk        (clk),
		.reset      (reset),
		.core_valid (core_valid),
		.core_word  (core_word),
		.core_ack   (core_ack),
		.lane_valid (lane_valid),
		.lane_word  (lane_word),
		.lane_ack   (lane_ack)
	);

	////////////////////////////////////////
	// serializer lanes
	////////////////////////////////////////

	for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
		word_serializer u_ser (
			.clk      (clk),
			.reset    (reset),
			.in_valid (lane_valid[i]),
			.in_word  (lane_word),
			.in_ack   (lane_ack[i]),
			.wrreq    (ser_wrreq[i]),
			.flit     (ser_flit[i]),
			.full     (fifo_full[i])
		);

		flit_fifo #(
			.DEPTH (`FIFO_DEPTH)
		) u_fifo (
			.clk   (clk),
			.reset (reset),
			.wrreq (ser_wrreq[i]),
			.flit  (ser_flit[i]),
			.full  (fifo_full[i]),
			.rdreq (fifo_rdreq[i]),
			.empty (fifo_empty[i]),
			.q     (fifo_q[i])
		);
	end

	flit_arbiter u_arb (
		.clk       (clk),
		.reset     (reset),
		.empty     (fifo_empty),
		.q         (fifo_q),
		.rdreq     (fifo_rdreq),
		.out_full  (out_full),
		.out_wrreq (out_wrreq),
		.out_flit  (out_flit)
	);

endmodule

//--- sim/tb_noc_injector.sv
`timescale 1ns/1ps
`include "noc_params.svh"

module tb_noc_injector import noc_pkg::*; ();

	localparam int NUM_WORDS = 400;
	localparam int TIMEOUT   = 2000;           // cycles allowed per wait
	localparam int HALF_W    = `PAYLOAD_W / 2;

	logic       clk;
	logic       reset;
	logic       core_valid;
	core_word_t core_word;
	logic       core_ack;
	logic       out_full;
	logic       out_wrreq;
	flit_t      out_flit;

	core_word_t lane_q [`NUM_LANES][$];  // accepted words, per lane, in order
	int route_set [8] = '{0, 3, 4, 6, 9, 16, 17, 31};  // 16 included, lanes shared

	int         mismatch_count;
	int         error_count;
	bit         timed_out;
	int         accepted;   // words taken by the dut
	int         rebuilt;    // words parsed back from flits
	int         headers;
	int         phase;      // 0 header, 1 code, 2 payload high, 3 payload low
	logic [`ROUTE_W-1:0] pkt_route;  // route of the open packet
	core_word_t part;                // word being rebuilt

	initial clk = 1'b0;
	always #2 clk = ~clk;  // 4 ns period

	noc_injector_top u_dut (
		.clk        (clk),
		.reset      (reset),
		.core_valid (core_valid),
		.core_word  (core_word),
		.core_ack   (core_ack),
		.out_full   (out_full),
		.out_wrreq  (out_wrreq),
		.out_flit   (out_flit)
	);

	////////////////////////////////////////
	// reference rules
	////////////////////////////////////////

	function automatic lane_idx_t lane_of(input logic [`ROUTE_W-1:0] route);
		return lane_idx_t'(route % `NUM_LANES);
	endfunction

	// header as the router expects it
	function automatic flit_t encode_header(input logic [`ROUTE_W-1:0] route);
		flit_t f;
		f = '0;
		if (route == `BCAST_ROUTE) begin
			f.body[`FLIT_W-2] = 1'b1;      // marker bit alone
		end else begin
			f.body[`ROUTE_W-1:0] = route;
		end
		return f;
	endfunction

	function automatic bit lanes_empty();
		for (int i = 0; i < `NUM_LANES; i++) begin
			if (lane_q[i].size() != 0) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	////////////////////////////////////////
	// compare and report
	////////////////////////////////////////

	task automatic check_word(input string name, input core_word_t expected,
		input core_word_t actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_flit(input string name, input flit_t expected, input flit_t actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH %s: expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic report_error(input string msg);
		error_count++;
		$display("ERROR: %s", msg);
	endtask

	////////////////////////////////////////
	// packet parser
	////////////////////////////////////////

	task automatic take_flit(input flit_t f);
		flit_t      exp_flit;
		core_word_t exp_word;
		lane_idx_t  lane;
		case (phase)
			0: begin
				// decode, then re-encode to check the format
				if (f.body == encode_header(`BCAST_ROUTE).body) begin
					pkt_route = `BCAST_ROUTE;
				end else begin
					pkt_route = f.body[`ROUTE_W-1:0];
				end
				check_flit("header flit", encode_header(pkt_route), f);
				headers++;
				phase = 1;
			end
			1: begin
				exp_flit = '0;                               // no tail, upper bits zero
				exp_flit.body[`CODE_W-1:0] = f.body[`CODE_W-1:0];
				check_flit("code flit", exp_flit, f);
				part.route = pkt_route;
				part.code  = f.body[`CODE_W-1:0];
				phase = 2;
			end
			2: begin
				exp_flit = f;
				exp_flit.tail = 1'b0;  // tail only closes a group
				check_flit("payload high flit", exp_flit, f);
				part.payload[`PAYLOAD_W-1:HALF_W] = f.body;
				phase = 3;
			end
			default: begin
				part.payload[HALF_W-1:0] = f.body;
				rebuilt++;
				lane = lane_of(pkt_route);
				if (lane_q[lane].size() == 0) begin
					report_error("flit group arrived with no accepted word left in its lane");
				end else begin
					exp_word = lane_q[lane].pop_front();
					check_word("rebuilt word", exp_word, part);
				end
				phase = f.tail ? 0 : 1;  // merged words go on with a code flit
			end
		endcase
	endtask

	// sample mid low phase, values hold up to the rising edge
	always begin
		@(negedge clk);
		#1;
		if (core_valid && core_ack) begin
			lane_q[lane_of(core_word.route)].push_back(core_word);
			accepted++;
		end
		if (out_wrreq && out_full) begin
			report_error("out_wrreq was high while out_full was high");
		end else if (out_wrreq) begin
			take_flit(out_flit);
		end
	end

	// router back-pressure, full about a third of the time
	always begin
		@(negedge clk);
		out_full = ($urandom % 3) == 0;
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	task automatic send_word(input core_word_t w);
		int gap;
		int waited;
		gap = $urandom % 3;  // idle cycles before the word
		repeat (gap) begin
			@(negedge clk);
			core_valid = 1'b0;
		end
		@(negedge clk);
		core_valid = 1'b1;
		core_word  = w;
		#1;
		waited = 0;
		while (!core_ack && waited < TIMEOUT) begin
			@(negedge clk);
			#1;
			waited++;
		end
		if (!core_ack) begin
			report_error("core_ack stayed low, word not accepted before timeout");
			timed_out = 1'b1;
		end else begin
			@(posedge clk);  // transfer edge
		end
	endtask

	initial begin
		core_word_t          w;
		logic [`ROUTE_W-1:0] run_route;
		int                  waited;

		void'($urandom(28603));
		mismatch_count = 0;
		error_count    = 0;
		timed_out      = 1'b0;
		accepted       = 0;
		rebuilt        = 0;
		headers        = 0;
		phase          = 0;
		part           = '0;
		pkt_route      = '0;
		reset          = 1'b1;
		core_valid     = 1'b0;
		core_word      = '0;
		out_full       = 1'b0;

		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#1;
		check_count("out_wrreq after reset", 0, int'(out_wrreq));
		check_count("core_ack after reset", 1, int'(core_ack));

		// runs of repeated routes so lanes get to merge
		run_route = route_set[0][`ROUTE_W-1:0];
		for (int n = 0; n < NUM_WORDS && !timed_out; n++) begin
			if (($urandom % 10) < 4) begin
				run_route = route_set[$urandom % 8][`ROUTE_W-1:0];
			end
			w.route   = run_route;
			w.code    = `CODE_W'($urandom);
			w.payload = `PAYLOAD_W'($urandom);
			send_word(w);
		end
		@(negedge clk);
		core_valid = 1'b0;

		// drain every lane model
		waited = 0;
		while (!lanes_empty() && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!lanes_empty()) begin
			report_error("lane queues did not drain before timeout");
			timed_out = 1'b1;
		end

		// quiet window, any extra flit trips the parser
		repeat (50) @(negedge clk);

		check_count("words accepted", NUM_WORDS, accepted);
		check_count("words rebuilt", accepted, rebuilt);
		check_count("open packet at end", 0, phase);
		if (headers >= rebuilt) begin
			report_error("same-route words never merged into one packet");
		end

		$display("errors: %0d mismatches, %0d other failures (%0d words, %0d packets)",
			mismatch_count, error_count, rebuilt, headers);
		if (mismatch_count == 0 && error_count == 0 && !timed_out) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+src
src/noc_pkg.sv
src/core_dispatch.sv
src/word_serializer.sv
src/flit_fifo.sv
src/flit_arbiter.sv
src/noc_injector_top.sv
sim/tb_noc_injector.sv

//--- run_sim.sh
#!/bin/sh
# build and run the noc injector testbench with Verilator

verilator --binary --timing -Wno-fatal --top-module tb_noc_injector -f sim.f \
	|| { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_noc_injector > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log

grep -q "TEST FAILED" sim.log && echo "simulation reported a failure" && exit 1
grep -q "TEST OK" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0
